// ==== design/rvCore.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCore (
    input  logic              clk,
    input  logic              rstN,
    input  logic              imemWe,
    input  logic [`XLEN-1:0]  imemAddr,
    input  logic [`XLEN-1:0]  imemData,
    input  rvPipePkg::regIdxT dbgAddr,
    output logic [`XLEN-1:0]  dbgData,
    output logic              retireValid,
    output rvPipePkg::regIdxT retireRd,
    output logic [`XLEN-1:0]  retireData
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    localparam int IMEM_AW = $clog2(`IMEM_WORDS);

    // Fetch
    logic [`XLEN-1:0] imem [0:`IMEM_WORDS-1] = '{default: '0};
    logic [`XLEN-1:0] pcF;
    logic [`XLEN-1:0] pcPlus4F;
    logic [`XLEN-1:0] instrF;

    // Decode
    logic [`XLEN-1:0] instrD;
    logic [`XLEN-1:0] pcD;
    logic [`XLEN-1:0] pcPlus4D;
    logic [`XLEN-1:0] immD;
    logic [`XLEN-1:0] rd1D;
    logic [`XLEN-1:0] rd2D;
    logic             regWriteD;
    logic             memWriteD;
    logic             memReadD;
    logic             branchD;
    logic             branchNeD;
    logic             jumpD;
    logic             aluSrcD;
    aluOpT            aluOpD;
    resultSrcT        resultSrcD;
    regIdxT           rs1D;
    regIdxT           rs2D;
    regIdxT           rdD;

    // Execute
    logic [`XLEN-1:0] rd1E;
    logic [`XLEN-1:0] rd2E;
    logic [`XLEN-1:0] pcE;
    logic [`XLEN-1:0] pcPlus4E;
    logic [`XLEN-1:0] immE;
    logic [`XLEN-1:0] aluResultE;
    logic [`XLEN-1:0] storeDataE;
    logic [`XLEN-1:0] pcTargetE;
    logic             redirectE;
    logic             regWriteE;
    logic             memWriteE;
    logic             memReadE;
    logic             branchE;
    logic             branchNeE;
    logic             jumpE;
    logic             aluSrcE;
    aluOpT            aluOpE;
    resultSrcT        resultSrcE;
    regIdxT           rs1E;
    regIdxT           rs2E;
    regIdxT           rdE;

    // Memory
    logic [`XLEN-1:0] aluResultM;
    logic [`XLEN-1:0] storeDataM;
    logic [`XLEN-1:0] pcPlus4M;
    logic [`XLEN-1:0] readDataM;
    logic             regWriteM;
    logic             memWriteM;
    resultSrcT        resultSrcM;
    regIdxT           rdM;

    // Writeback
    logic [`XLEN-1:0] aluResultW;
    logic [`XLEN-1:0] readDataW;
    logic [`XLEN-1:0] pcPlus4W;
    logic [`XLEN-1:0] resultW;
    logic             regWriteW;
    resultSrcT        resultSrcW;
    regIdxT           rdW;

    fwdSelT fwdA;
    fwdSelT fwdB;
    logic   stall;
    logic   flush;

    // Program loading happens while the core is held in reset
    always_ff @(posedge clk) begin
        if (imemWe)
            imem[imemAddr[IMEM_AW+1:2]] <= imemData;
    end

    assign instrF   = imem[pcF[IMEM_AW+1:2]];
    assign pcPlus4F = pcF + 32'd4;

    always_ff @(posedge clk) begin
        if (!rstN)
            pcF <= `RESET_PC;
        else if (redirectE || !stall)
            pcF <= redirectE ? pcTargetE : pcPlus4F;
    end

    // Fetch/decode register, an all-zero word decodes as a bubble
    always_ff @(posedge clk) begin
        if (!rstN || flush)
            instrD <= '0;
        else if (!stall)
            instrD <= instrF;
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD      <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD  = instrD[11:7];

    rvDecode decode_i (
        .instr     (instrD),
        .regWrite  (regWriteD),
        .memWrite  (memWriteD),
        .memRead   (memReadD),
        .branch    (branchD),
        .branchNe  (branchNeD),
        .jump      (jumpD),
        .aluSrc    (aluSrcD),
        .aluOp     (aluOpD),
        .resultSrc (resultSrcD),
        .imm       (immD)
    );

    rvRegFile regFile_i (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (rs1D),
        .rs2     (rs2D),
        .rd      (rdW),
        .we      (regWriteW),
        .wd      (resultW),
        .dbgAddr (dbgAddr),
        .rd1     (rd1D),
        .rd2     (rd2D),
        .dbgData (dbgData)
    );

    rvHazard hazard_i (
        .rs1D      (rs1D),
        .rs2D      (rs2D),
        .rs1E      (rs1E),
        .rs2E      (rs2E),
        .rdE       (rdE),
        .rdM       (rdM),
        .rdW       (rdW),
        .memReadE  (memReadE),
        .regWriteM (regWriteM),
        .regWriteW (regWriteW),
        .redirect  (redirectE),
        .fwdA      (fwdA),
        .fwdB      (fwdB),
        .stall     (stall),
        .flush     (flush)
    );

    // Decode/execute register, stall or flush leaves a bubble
    always_ff @(posedge clk) begin
        if (!rstN || flush || stall) begin
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            memReadE  <= 1'b0;
            branchE   <= 1'b0;
            jumpE     <= 1'b0;
        end else begin
            regWriteE <= regWriteD;
            memWriteE <= memWriteD;
            memReadE  <= memReadD;
            branchE   <= branchD;
            jumpE     <= jumpD;
        end
    end

    always_ff @(posedge clk) begin
        rd1E       <= rd1D;
        rd2E       <= rd2D;
        pcE        <= pcD;
        pcPlus4E   <= pcPlus4D;
        immE       <= immD;
        branchNeE  <= branchNeD;
        aluSrcE    <= aluSrcD;
        aluOpE     <= aluOpD;
        resultSrcE <= resultSrcD;
        rs1E       <= rs1D;
        rs2E       <= rs2D;
        rdE        <= rdD;
    end

    rvExecute execute_i (
        .rd1        (rd1E),
        .rd2        (rd2E),
        .resultW    (resultW),
        .aluResultM (aluResultM),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .imm        (immE),
        .pc         (pcE),
        .aluSrc     (aluSrcE),
        .aluOp      (aluOpE),
        .branch     (branchE),
        .branchNe   (branchNeE),
        .jump       (jumpE),
        .aluResult  (aluResultE),
        .storeData  (storeDataE),
        .pcTarget   (pcTargetE),
        .redirect   (redirectE)
    );

    // Execute/memory register
    always_ff @(posedge clk) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResultE;
        storeDataM <= storeDataE;
        pcPlus4M   <= pcPlus4E;
        resultSrcM <= resultSrcE;
        rdM        <= rdE;
    end

    // Memory/writeback register
    always_ff @(posedge clk) begin
        if (!rstN)
            regWriteW <= 1'b0;
        else
            regWriteW <= regWriteM;
    end

    always_ff @(posedge clk) begin
        aluResultW <= aluResultM;
        readDataW  <= readDataM;
        pcPlus4W   <= pcPlus4M;
        resultSrcW <= resultSrcM;
        rdW        <= rdM;
    end

    rvResult result_i (
        .clk        (clk),
        .memWrite   (memWriteM),
        .addr       (aluResultM),
        .storeData  (storeDataM),
        .aluResultW (aluResultW),
        .readDataW  (readDataW),
        .pcPlus4W   (pcPlus4W),
        .resultSrcW (resultSrcW),
        .readData   (readDataM),
        .result     (resultW)
    );

    // Writes to x0 are not reported
    assign retireValid = regWriteW && rdW != 5'd0;
    assign retireRd    = rdW;
    assign retireData  = resultW;

endmodule

// ==== design/rvCore_config.svh ====
`ifndef RVCORE_CONFIG_SVH
`define RVCORE_CONFIG_SVH

// Core is fixed at 32 bits
`define XLEN 32

// Depths in 32-bit words
`define IMEM_WORDS 64
`define DMEM_WORDS 64

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== design/rvDecode.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvDecode (
    input  logic [`XLEN-1:0]    instr,
    output logic                regWrite,
    output logic                memWrite,
    output logic                memRead,
    output logic                branch,
    output logic                branchNe,
    output logic                jump,
    output logic                aluSrc,
    output rvIsaPkg::aluOpT     aluOp,
    output rvIsaPkg::resultSrcT resultSrc,
    output logic [`XLEN-1:0]    imm
);
    import rvIsaPkg::*;

    opcodeT     opcode;
    immFmtT     immFmt;
    logic [2:0] funct3;

    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];

    always_comb begin
        // Bubble unless the opcode is recognised
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        branch    = 1'b0;
        branchNe  = 1'b0;
        jump      = 1'b0;
        aluSrc    = 1'b0;
        aluOp     = ADD;
        resultSrc = RES_ALU;
        immFmt    = IMM_I;
        case (opcode)
            OP: begin
                regWrite = 1'b1;
                case (funct3)
                    3'b000:  aluOp = instr[30] ? SUB : ADD;
                    3'b111:  aluOp = AND;
                    3'b110:  aluOp = OR;
                    3'b100:  aluOp = XOR;
                    3'b010:  aluOp = SLT;
                    default: regWrite = 1'b0;
                endcase
            end
            OP_IMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                case (funct3)
                    3'b000:  aluOp = ADD;
                    3'b111:  aluOp = AND;
                    3'b110:  aluOp = OR;
                    default: regWrite = 1'b0;
                endcase
            end
            LUI: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                aluOp    = PASS_B;
                immFmt   = IMM_U;
            end
            LOAD: begin
                regWrite  = 1'b1;
                memRead   = 1'b1;
                aluSrc    = 1'b1;
                resultSrc = RES_MEM;
            end
            STORE: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immFmt   = IMM_S;
            end
            BRANCH: begin
                // BEQ and BNE only
                branch   = (funct3[2:1] == 2'b00);
                branchNe = funct3[0];
                immFmt   = IMM_B;
            end
            JAL: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                resultSrc = RES_PC4;
                immFmt    = IMM_J;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (immFmt)
            IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            IMM_U:   imm = {instr[31:12], 12'b0};
            IMM_J:   imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== design/rvExecute.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvExecute (
    input  logic [`XLEN-1:0]  rd1,
    input  logic [`XLEN-1:0]  rd2,
    input  logic [`XLEN-1:0]  resultW,
    input  logic [`XLEN-1:0]  aluResultM,
    input  rvPipePkg::fwdSelT fwdA,
    input  rvPipePkg::fwdSelT fwdB,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  pc,
    input  logic              aluSrc,
    input  rvIsaPkg::aluOpT   aluOp,
    input  logic              branch,
    input  logic              branchNe,
    input  logic              jump,
    output logic [`XLEN-1:0]  aluResult,
    output logic [`XLEN-1:0]  storeData,
    output logic [`XLEN-1:0]  pcTarget,
    output logic              redirect
);
    import rvIsaPkg::*;
    import rvPipePkg::*;

    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic             equal;

    function automatic logic [`XLEN-1:0] fwdMux(input fwdSelT sel,
                                                input logic [`XLEN-1:0] regVal,
                                                input logic [`XLEN-1:0] wbVal,
                                                input logic [`XLEN-1:0] memVal);
        case (sel)
            FWD_WB:  return wbVal;
            FWD_MEM: return memVal;
            default: return regVal;
        endcase
    endfunction

    assign srcA      = fwdMux(fwdA, rd1, resultW, aluResultM);
    assign storeData = fwdMux(fwdB, rd2, resultW, aluResultM);
    assign srcB      = aluSrc ? imm : storeData;

    always_comb begin
        case (aluOp)
            ADD:     aluResult = srcA + srcB;
            SUB:     aluResult = srcA - srcB;
            AND:     aluResult = srcA & srcB;
            OR:      aluResult = srcA | srcB;
            XOR:     aluResult = srcA ^ srcB;
            SLT:     aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(srcB)};
            PASS_B:  aluResult = srcB;
            default: aluResult = '0;
        endcase
    end

    // Branch compares the forwarded register operands, not the ALU inputs
    assign equal    = (srcA == storeData);
    assign pcTarget = pc + imm;
    assign redirect = jump || (branch && (equal != branchNe));

endmodule

// ==== design/rvHazard.sv ====
`timescale 1ns/1ps

module rvHazard (
    input  rvPipePkg::regIdxT rs1D,
    input  rvPipePkg::regIdxT rs2D,
    input  rvPipePkg::regIdxT rs1E,
    input  rvPipePkg::regIdxT rs2E,
    input  rvPipePkg::regIdxT rdE,
    input  rvPipePkg::regIdxT rdM,
    input  rvPipePkg::regIdxT rdW,
    input  logic              memReadE,
    input  logic              regWriteM,
    input  logic              regWriteW,
    input  logic              redirect,
    output rvPipePkg::fwdSelT fwdA,
    output rvPipePkg::fwdSelT fwdB,
    output logic              stall,
    output logic              flush
);
    import rvPipePkg::*;

    // Memory stage wins over writeback, never for x0
    function automatic fwdSelT fwdFor(input regIdxT rs, input regIdxT rdMem,
                                      input logic wrMem, input regIdxT rdWb,
                                      input logic wrWb);
        if (rs == 5'd0)
            return FWD_REG;
        else if (wrMem && rdMem == rs)
            return FWD_MEM;
        else if (wrWb && rdWb == rs)
            return FWD_WB;
        else
            return FWD_REG;
    endfunction

    assign fwdA = fwdFor(rs1E, rdM, regWriteM, rdW, regWriteW);
    assign fwdB = fwdFor(rs2E, rdM, regWriteM, rdW, regWriteW);

    // Load in execute feeding the instruction in decode
    assign stall = memReadE && rdE != 5'd0 && (rdE == rs1D || rdE == rs2D);

    assign flush = redirect;

endmodule

// ==== design/rvIsaPkg.sv ====
package rvIsaPkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcodeT;

    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLT    = 4'd5,
        PASS_B = 4'd6
    } aluOpT;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immFmtT;

    // Writeback result source
    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrcT;

endpackage

// ==== design/rvPipePkg.sv ====
package rvPipePkg;

    // Architectural register index
    typedef logic [4:0] regIdxT;

    // Operand source for the execute stage
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } fwdSelT;

endpackage

// ==== design/rvRegFile.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvRegFile (
    input  logic                clk,
    input  logic                rstN,
    input  rvPipePkg::regIdxT   rs1,
    input  rvPipePkg::regIdxT   rs2,
    input  rvPipePkg::regIdxT   rd,
    input  logic                we,
    input  logic [`XLEN-1:0]    wd,
    input  rvPipePkg::regIdxT   dbgAddr,
    output logic [`XLEN-1:0]    rd1,
    output logic [`XLEN-1:0]    rd2,
    output logic [`XLEN-1:0]    dbgData
);
    import rvPipePkg::*;

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:31];

    // Write-first read port
    function automatic logic [`XLEN-1:0] readReg(input regIdxT idx);
        if (idx == 5'd0)
            return '0;
        else if (we && idx == rd)
            return wd;
        else
            return regs[idx];
    endfunction

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    always_comb begin
        rd1     = readReg(rs1);
        rd2     = readReg(rs2);
        dbgData = readReg(dbgAddr);
    end

endmodule

// ==== design/rvResult.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvResult (
    input  logic                clk,
    input  logic                memWrite,
    input  logic [`XLEN-1:0]    addr,
    input  logic [`XLEN-1:0]    storeData,
    input  logic [`XLEN-1:0]    aluResultW,
    input  logic [`XLEN-1:0]    readDataW,
    input  logic [`XLEN-1:0]    pcPlus4W,
    input  rvIsaPkg::resultSrcT resultSrcW,
    output logic [`XLEN-1:0]    readData,
    output logic [`XLEN-1:0]    result
);
    import rvIsaPkg::*;

    localparam int DMEM_AW = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0]   dmem [0:`DMEM_WORDS-1] = '{default: '0};
    logic [DMEM_AW-1:0] wordIdx;

    // Word addressed, byte offset ignored
    assign wordIdx = addr[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (memWrite)
            dmem[wordIdx] <= storeData;
    end

    assign readData = dmem[wordIdx];

    always_comb begin
        case (resultSrcW)
            RES_MEM: result = readDataW;
            RES_PC4: result = pcPlus4W;
            default: result = aluResultW;
        endcase
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the rvCore testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module rvCoreTb \
    -f rvCore.f -o rvCoreSim &&
    ./obj_dir/rvCoreSim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" &&
    echo "rvCore simulation passed" ||
    { echo "rvCore simulation failed"; exit 1; }

// ==== rvCore.f ====
+incdir+design
design/rvIsaPkg.sv
design/rvPipePkg.sv
design/rvDecode.sv
design/rvRegFile.sv
design/rvHazard.sv
design/rvExecute.sv
design/rvResult.sv
design/rvCore.sv
sim/rvCore_checker.sv
sim/rvCoreTb.sv

// ==== sim/rvCoreTb.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCoreTb;
    import rvPipePkg::*;

    localparam logic [6:0] opcReg    = 7'b0110011;
    localparam logic [6:0] opcImm    = 7'b0010011;
    localparam logic [6:0] opcLui    = 7'b0110111;
    localparam logic [6:0] opcLoad   = 7'b0000011;
    localparam logic [6:0] opcStore  = 7'b0100011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcJal    = 7'b1101111;

    logic             clk;
    logic             rstN;
    logic             imemWe;
    logic [`XLEN-1:0] imemAddr;
    logic [`XLEN-1:0] imemData;
    regIdxT           dbgAddr;
    logic [`XLEN-1:0] dbgData;
    logic             retireValid;
    regIdxT           retireRd;
    logic [`XLEN-1:0] retireData;

    int               seed = 32'heb3b;
    int               lastWait;
    logic [`XLEN-1:0] prog [$];
    regIdxT           expRd [$];
    logic [`XLEN-1:0] expVal [$];
    logic [`XLEN-1:0] refRegs [0:31];

    rvCore dut_i (
        .clk         (clk),
        .rstN        (rstN),
        .imemWe      (imemWe),
        .imemAddr    (imemAddr),
        .imemData    (imemData),
        .dbgAddr     (dbgAddr),
        .dbgData     (dbgData),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] encR(input logic [2:0] f3, input logic sub,
                                         input regIdxT rd, input regIdxT rs1, input regIdxT rs2);
        return {1'b0, sub, 5'b0, rs2, rs1, f3, rd, opcReg};
    endfunction

    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                         input regIdxT rd, input regIdxT rs1,
                                         input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input regIdxT rs2, input regIdxT rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcStore};
    endfunction

    // ne selects BNE, otherwise BEQ
    function automatic logic [31:0] encB(input logic ne, input regIdxT rs1, input regIdxT rs2,
                                         input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], opcBranch};
    endfunction

    function automatic logic [31:0] encJ(input regIdxT rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opcJal};
    endfunction

    function automatic logic [31:0] encU(input regIdxT rd, input logic [19:0] imm);
        return {imm, rd, opcLui};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic logic [31:0] lessThan(input logic [31:0] x, input logic [31:0] y);
        return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
    endfunction

    function automatic logic [11:0] randImm();
        logic [31:0] r;
        r = $random(seed);
        return r[11:0];
    endfunction

    task automatic stopRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkReg(input string name, input regIdxT got, input regIdxT exp);
        if (got !== exp)
            stopRun($sformatf("Mismatch at %0t: %s got x%0d expected x%0d",
                              $time, name, got, exp));
    endtask

    task automatic checkData(input string name, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        if (got !== exp)
            stopRun($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic startProgram();
        prog.delete();
        expRd.delete();
        expVal.delete();
        for (int i = 0; i < 32; i++)
            refRegs[i] = '0;
    endtask

    task automatic emit(input logic [31:0] word);
        prog.push_back(word);
    endtask

    // Reference retire list, built in program order
    task automatic expectWrite(input regIdxT rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            expRd.push_back(rd);
            expVal.push_back(value);
            refRegs[rd] = value;
        end
    endtask

    task automatic loadProgram();
        int cycles;
        cycles = (prog.size() > 3) ? prog.size() : 3;
        @(posedge clk);
        #2;
        rstN = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            imemWe   = (i < prog.size());
            imemAddr = i * 4;
            imemData = (i < prog.size()) ? prog[i] : '0;
            @(posedge clk);
            #2;
            if (retireValid)
                stopRun("retireValid went high while reset was held");
        end
        imemWe = 1'b0;
        rstN   = 1'b1;
    endtask

    task automatic expectRetire(input regIdxT rd, input logic [`XLEN-1:0] value);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!retireValid) begin
            cycles++;
            if (cycles >= 200)
                stopRun($sformatf("timed out waiting for the retire of x%0d", rd));
            @(negedge clk);
        end
        lastWait = cycles;
        checkReg("retireRd", retireRd, rd);
        checkData("retireData", retireData, value);
    endtask

    task automatic expectQuiet(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (retireValid)
                stopRun($sformatf("unexpected retire of x%0d at %0t", retireRd, $time));
        end
    endtask

    task automatic checkRegFile();
        for (int i = 0; i < 32; i++) begin
            @(posedge clk);
            #2;
            dbgAddr = regIdxT'(i);
            @(negedge clk);
            checkData($sformatf("dbgData x%0d", i), dbgData, refRegs[i]);
        end
    endtask

    task automatic runProgram();
        loadProgram();
        foreach (expRd[i]) begin
            expectRetire(expRd[i], expVal[i]);
            // Fetch, decode, execute and memory cycles come before writeback
            if (i == 0 && lastWait != 4)
                stopRun($sformatf("first retire came after %0d cycles, not 4", lastWait));
        end
        expectQuiet(8);
        checkRegFile();
    endtask

    task automatic aluOps();
        logic [11:0] a;
        logic [11:0] b;
        logic [11:0] c;
        logic [31:0] u;
        startProgram();
        a = randImm();
        b = randImm();
        c = randImm();
        u = $random(seed);
        emit(encI(opcImm, 3'b000, 1, 0, a));
        expectWrite(1, sext12(a));
        emit(encI(opcImm, 3'b000, 2, 0, b));
        expectWrite(2, sext12(b));
        emit(encR(3'b000, 1'b0, 3, 1, 2));
        expectWrite(3, refRegs[1] + refRegs[2]);
        emit(encR(3'b000, 1'b1, 4, 1, 2));
        expectWrite(4, refRegs[1] - refRegs[2]);
        emit(encR(3'b111, 1'b0, 5, 1, 2));
        expectWrite(5, refRegs[1] & refRegs[2]);
        emit(encR(3'b110, 1'b0, 6, 1, 2));
        expectWrite(6, refRegs[1] | refRegs[2]);
        emit(encR(3'b100, 1'b0, 7, 1, 2));
        expectWrite(7, refRegs[1] ^ refRegs[2]);
        emit(encR(3'b010, 1'b0, 8, 1, 2));
        expectWrite(8, lessThan(refRegs[1], refRegs[2]));
        emit(encR(3'b010, 1'b0, 12, 2, 1));
        expectWrite(12, lessThan(refRegs[2], refRegs[1]));
        emit(encI(opcImm, 3'b111, 9, 1, c));
        expectWrite(9, refRegs[1] & sext12(c));
        emit(encI(opcImm, 3'b110, 10, 2, c));
        expectWrite(10, refRegs[2] | sext12(c));
        emit(encU(11, u[31:12]));
        expectWrite(11, {u[31:12], 12'b0});
        emit(encJ(0, 21'd0));
        runProgram();
    endtask

    // Each instruction consumes the result of the one before it
    task automatic forwardChain();
        logic [11:0] a;
        logic [11:0] b;
        startProgram();
        a = randImm();
        b = randImm();
        emit(encI(opcImm, 3'b000, 1, 0, a));
        expectWrite(1, sext12(a));
        emit(encR(3'b000, 1'b0, 2, 1, 1));
        expectWrite(2, refRegs[1] + refRegs[1]);
        emit(encR(3'b000, 1'b1, 3, 2, 1));
        expectWrite(3, refRegs[2] - refRegs[1]);
        emit(encR(3'b100, 1'b0, 4, 3, 2));
        expectWrite(4, refRegs[3] ^ refRegs[2]);
        emit(encR(3'b110, 1'b0, 5, 4, 1));
        expectWrite(5, refRegs[4] | refRegs[1]);
        emit(encI(opcImm, 3'b000, 6, 5, b));
        expectWrite(6, refRegs[5] + sext12(b));
        emit(encR(3'b111, 1'b0, 7, 6, 5));
        expectWrite(7, refRegs[6] & refRegs[5]);
        emit(encR(3'b010, 1'b0, 8, 7, 6));
        expectWrite(8, lessThan(refRegs[7], refRegs[6]));
        emit(encJ(0, 21'd0));
        runProgram();
    endtask

    task automatic loadUse();
        logic [11:0] a;
        logic [11:0] b;
        startProgram();
        a = randImm();
        b = randImm();
        emit(encI(opcImm, 3'b000, 1, 0, 12'h080));
        expectWrite(1, 32'h80);
        emit(encI(opcImm, 3'b000, 2, 0, a));
        expectWrite(2, sext12(a));
        emit(encS(2, 1, 12'd8));
        emit(encI(opcLoad, 3'b010, 3, 1, 12'd8));
        expectWrite(3, refRegs[2]);
        emit(encR(3'b000, 1'b0, 4, 3, 2));
        expectWrite(4, refRegs[3] + refRegs[2]);
        // Word at 0xF0 is never stored to
        emit(encI(opcLoad, 3'b010, 5, 1, 12'h070));
        expectWrite(5, 32'd0);
        emit(encI(opcImm, 3'b000, 6, 5, b));
        expectWrite(6, sext12(b));
        emit(encS(4, 1, 12'd12));
        emit(encI(opcLoad, 3'b010, 7, 1, 12'd12));
        expectWrite(7, refRegs[4]);
        emit(encJ(0, 21'd0));
        runProgram();
    endtask

    // Skipped slots write x3 and x6, which must never retire
    task automatic branchSkip();
        startProgram();
        emit(encI(opcImm, 3'b000, 1, 0, 12'd5));
        expectWrite(1, 32'd5);
        emit(encI(opcImm, 3'b000, 2, 0, 12'd5));
        expectWrite(2, 32'd5);
        emit(encB(1'b0, 1, 2, 13'd12));
        emit(encI(opcImm, 3'b000, 3, 0, 12'd1));
        emit(encI(opcImm, 3'b000, 3, 0, 12'd2));
        emit(encB(1'b1, 1, 2, 13'd12));
        emit(encI(opcImm, 3'b000, 4, 0, 12'd3));
        expectWrite(4, 32'd3);
        emit(encB(1'b0, 1, 0, 13'd8));
        emit(encI(opcImm, 3'b000, 5, 0, 12'd4));
        expectWrite(5, 32'd4);
        emit(encB(1'b1, 1, 0, 13'd12));
        emit(encI(opcImm, 3'b000, 6, 0, 12'd7));
        emit(encI(opcImm, 3'b000, 6, 0, 12'd8));
        emit(encI(opcImm, 3'b000, 7, 0, 12'd9));
        expectWrite(7, 32'd9);
        // Count down to zero with a backward BNE
        emit(encI(opcImm, 3'b000, 8, 0, 12'd3));
        expectWrite(8, 32'd3);
        emit(encI(opcImm, 3'b000, 8, 8, 12'hfff));
        emit(encB(1'b1, 8, 0, 13'h1ffc));
        for (int n = 2; n >= 0; n--)
            expectWrite(8, n);
        emit(encJ(0, 21'd0));
        runProgram();
    endtask

    task automatic jumpLink();
        logic [11:0] a;
        startProgram();
        a = randImm();
        emit(encI(opcImm, 3'b000, 1, 0, a));
        expectWrite(1, sext12(a));
        emit(encI(opcImm, 3'b000, 0, 0, 12'd5));
        emit(encR(3'b000, 1'b0, 9, 0, 1));
        expectWrite(9, refRegs[1]);
        // JAL at 0x0C links 0x10 and lands on 0x18
        emit(encJ(2, 21'd12));
        expectWrite(2, 32'h10);
        emit(encI(opcImm, 3'b000, 3, 0, 12'd1));
        emit(encI(opcImm, 3'b000, 3, 0, 12'd2));
        emit(encR(3'b000, 1'b0, 4, 2, 1));
        expectWrite(4, refRegs[2] + refRegs[1]);
        emit(encJ(0, 21'd8));
        emit(encI(opcImm, 3'b000, 5, 0, 12'd1));
        emit(encJ(0, 21'd0));
        runProgram();
    endtask

    initial begin
        rstN     = 1'b0;
        imemWe   = 1'b0;
        imemAddr = '0;
        imemData = '0;
        dbgAddr  = '0;
        aluOps();
        forwardChain();
        loadUse();
        branchSkip();
        jumpLink();
        if (dut_i.checker_i.failCount == 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("%0d assertion failures in the pipeline checker",
                     dut_i.checker_i.failCount);
            $display("*** TEST FAILED ***");
            $fatal(1, "pipeline checker reported failures");
        end
    end

endmodule

// ==== sim/rvCore_checker.sv ====
`timescale 1ns/1ps
`include "rvCore_config.svh"

module rvCoreChecker (
    input logic              clk,
    input logic              rstN,
    input logic              retireValid,
    input rvPipePkg::regIdxT retireRd,
    input logic              stall,
    input logic              redirect,
    input logic [`XLEN-1:0]  pc,
    input rvPipePkg::regIdxT rs1E,
    input rvPipePkg::regIdxT rs2E,
    input rvPipePkg::fwdSelT fwdA,
    input rvPipePkg::fwdSelT fwdB
);
    import rvPipePkg::*;

    int failCount = 0;

    retireNotX0: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> retireRd != 5'd0)
    else begin
        failCount++;
        $error("retire reported for x0");
    end

    // A load-use stall freezes fetch unless execute redirects
    pcHeldOnStall: assert property (@(posedge clk) disable iff (!rstN)
        (stall && !redirect) |=> pc == $past(pc))
    else begin
        failCount++;
        $error("PC moved during a stall without a redirect");
    end

    noFwdForX0: assert property (@(posedge clk) disable iff (!rstN)
        (rs1E != 5'd0 || fwdA == FWD_REG) && (rs2E != 5'd0 || fwdB == FWD_REG))
    else begin
        failCount++;
        $error("forwarding selected for an x0 source");
    end

    // Checked one edge later, once the reset has cleared the writeback stage
    quietInReset: assert property (@(posedge clk) !rstN |=> !retireValid)
    else begin
        failCount++;
        $error("retireValid high during reset");
    end

endmodule

bind rvCore rvCoreChecker checker_i (
    .clk         (clk),
    .rstN        (rstN),
    .retireValid (retireValid),
    .retireRd    (retireRd),
    .stall       (stall),
    .redirect    (redirectE),
    .pc          (pcF),
    .rs1E        (rs1E),
    .rs2E        (rs2E),
    .fwdA        (fwdA),
    .fwdB        (fwdB)
);
